/* hw/brainwars_config.svh */
`ifndef BRAINWARS_CONFIG_SVH
`define BRAINWARS_CONFIG_SVH

// keypad geometry, rows and columns alike
`define KEYPAD_WIDTH 4

`define SCAN_DIV 4 // clk cycles per scan tick, small for sim
`define DEB_TICKS 3 // stable ticks before a press counts

`define LFSR_SEED 16'hACE1 // nonzero start of target sequence

`define LCD_EN_CYCLES 2 // high time of one LCD_en strobe
`define FRAME_BYTES 16 // bytes streamed per frame

`endif

/* hw/game_pkg.sv */
`default_nettype none

package game_pkg;

	typedef logic [3:0] key_t; // row*4 + col
	typedef logic [7:0] score_t; // saturating count
	typedef logic [15:0] lfsr_t; // target generator state

	////////////////////////////////////////////////////////////
	// frame layout
	////////////////////////////////////////////////////////////
	localparam int TARGET_KEYS = 14; // bytes 0..13 mark the target
	localparam int MISS_BYTE = 14;
	localparam int HIT_BYTE = 15;

	localparam score_t SCORE_MAX = 8'hFF; // counters stop here

endpackage

`default_nettype wire

/* hw/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

	// one bus word, read as instruction or as pixel byte
	typedef union packed {
		struct packed {
			logic [1:0] op; // opcode field
			logic [5:0] arg; // operand field
		} instr;
		logic [7:0] pixel; // 8 vertical pixels
	} lcd_word_u;

	////////////////////////////////////////////////////////////
	// instruction opcodes, top two bits of the word
	////////////////////////////////////////////////////////////
	localparam logic [1:0] OP_DISPLAY = 2'b00; // 0x3E/0x3F
	localparam logic [1:0] OP_COLUMN = 2'b01; // 0x40 + y
	localparam logic [1:0] OP_PAGE = 2'b10; // 0xB8 + x
	localparam logic [1:0] OP_START = 2'b11; // 0xC0 + line

	localparam logic [5:0] ARG_DISPLAY_ON = 6'h3F;
	localparam logic [5:0] ARG_PAGE_BASE = 6'h38; // page 0
	localparam logic [5:0] ARG_ZERO = 6'h00; // line 0 / column 0

endpackage

`default_nettype wire

/* hw/scan_tick.sv */
`timescale 1ns/1ps
`default_nettype none
`include "brainwars_config.svh"

module scan_tick #(
	parameter int DIV = `SCAN_DIV // cycles per tick, 2 or more
) (
	input  logic clk, // system clock
	input  logic rst_n, // sync reset, active low
	output logic tick // one-cycle enable
);
	localparam int CW = $clog2(DIV);

	logic [CW-1:0] cnt; // position inside the period

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
			tick <= 1'b0;
		end else begin
			tick <= (cnt == CW'(DIV - 1)); // fires once per wrap
			cnt <= (cnt == CW'(DIV - 1)) ? '0 : cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/keypad_scan.sv */
`timescale 1ns/1ps
`default_nettype none
`include "brainwars_config.svh"

module keypad_scan (
	input  logic clk, // system clock
	input  logic rst_n, // sync reset, active low
	input  logic tick, // scan step enable
	input  logic [`KEYPAD_WIDTH-1:0] col_n, // columns, low = closed
	output logic [`KEYPAD_WIDTH-1:0] row_n, // row strobe, one low
	output game_pkg::key_t key, // last key seen
	output logic pressed // held while any key is down
);
	import game_pkg::*;

	localparam int W = `KEYPAD_WIDTH;
	localparam int RW = $clog2(W);

	logic [RW-1:0] row_idx; // row being strobed
	logic [RW-1:0] col_idx; // lowest closed column
	logic col_hit; // some column reads low
	logic seen; // low column met in this sweep

	assign row_n = ~(W'(1) << row_idx);

	always_comb begin
		col_hit = 1'b0;
		col_idx = '0;
		for (int c = W - 1; c >= 0; c--) begin // lowest index wins
			if (!col_n[c]) begin
				col_hit = 1'b1;
				col_idx = RW'(c);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// row rotation and pressed flag
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			row_idx <= '0;
			pressed <= 1'b0;
			seen <= 1'b0;
		end else if (tick) begin
			row_idx <= row_idx + 1'b1; // sample current row, then move on
			if (col_hit)
				pressed <= 1'b1;
			if (row_idx == RW'(W - 1)) begin // sweep ends here
				seen <= 1'b0;
				if (!seen && !col_hit)
					pressed <= 1'b0; // whole sweep was quiet
			end else if (col_hit) begin
				seen <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tick && col_hit)
			key <= key_t'({row_idx, col_idx}); // row*4 + col
	end

	// the columns only make sense with a single row driven
	a_one_row: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~row_n));

endmodule

`default_nettype wire

/* hw/debounce_one_pulse.sv */
`timescale 1ns/1ps
`default_nettype none
`include "brainwars_config.svh"

module debounce_one_pulse #(
	parameter int DEPTH = `DEB_TICKS // ticks of stable level, 2 or more
) (
	input  logic clk, // system clock
	input  logic rst_n, // sync reset, active low
	input  logic tick, // sample enable
	input  logic pressed, // raw flag from the scanner
	output logic press_pulse // one clk per press
);
	logic [DEPTH-1:0] hist; // sampled history, newest in bit 0
	logic [DEPTH-1:0] hist_nx;
	logic fired; // pulse already given for this press

	assign hist_nx = {hist[DEPTH-2:0], pressed};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hist <= '0;
			fired <= 1'b0;
			press_pulse <= 1'b0;
		end else begin
			press_pulse <= 1'b0;
			if (tick) begin
				hist <= hist_nx;
				if (&hist_nx && !fired) begin // stable high
					press_pulse <= 1'b1;
					fired <= 1'b1;
				end else if (~|hist_nx) begin
					fired <= 1'b0; // released long enough, rearm
				end
			end
		end
	end

	// flick_game counts once per cycle of pulse
	a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		press_pulse |=> !press_pulse);

endmodule

`default_nettype wire

/* hw/flick_game.sv */
`timescale 1ns/1ps
`default_nettype none
`include "brainwars_config.svh"

module flick_game (
	input  logic clk, // system clock
	input  logic rst_n, // sync reset, active low
	input  logic game_en, // presses count only when high
	input  logic press_pulse, // debounced press
	input  game_pkg::key_t key, // key of that press
	output logic [127:0] frame // screen content, byte k at [8k+:8]
);
	import game_pkg::*;

	lfsr_t lfsr; // target sequence
	logic lfsr_fb;
	key_t target; // key to hit
	score_t hit_cnt;
	score_t miss_cnt;

	assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // taps 16,14,13,11
	assign target = key_t'(lfsr[3:0] % TARGET_KEYS);

	////////////////////////////////////////////////////////////
	// scoring
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lfsr <= `LFSR_SEED;
			hit_cnt <= '0;
			miss_cnt <= '0;
		end else if (press_pulse && game_en) begin
			if (key == target) begin
				lfsr <= {lfsr[14:0], lfsr_fb}; // new target on a hit
				if (hit_cnt != SCORE_MAX)
					hit_cnt <= hit_cnt + 1'b1;
			end else if (miss_cnt != SCORE_MAX) begin
				miss_cnt <= miss_cnt + 1'b1;
			end
		end
	end

	// frame: target bar, then miss and hit bytes
	always_comb begin
		frame = '0;
		for (int k = 0; k < TARGET_KEYS; k++) begin
			frame[8*k +: 8] = (target == key_t'(k)) ? 8'hFF : 8'h00;
		end
		frame[8*MISS_BYTE +: 8] = miss_cnt;
		frame[8*HIT_BYTE +: 8] = hit_cnt;
	end

endmodule

`default_nettype wire

/* hw/frame_ram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "brainwars_config.svh"

module frame_ram_ctrl (
	input  logic clk, // system clock
	input  logic rst_n, // sync reset, active low
	input  logic en_tran, // byte taken by the LCD side
	input  logic [127:0] frame, // live game frame
	output lcd_pkg::lcd_word_u data_byte, // byte on offer
	output logic data_valid // data_byte may be taken
);
	localparam int IW = $clog2(`FRAME_BYTES);

	logic [IW-1:0] idx; // byte on offer
	logic [127:0] snap; // frozen copy of frame

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idx <= '0;
			data_valid <= 1'b0;
		end else if (en_tran) begin
			data_valid <= 1'b0; // one idle cycle per byte
			idx <= idx + 1'b1; // wraps after byte 15
		end else if (!data_valid) begin
			data_valid <= 1'b1;
		end
	end

	// new copy right before byte 0 goes out
	always_ff @(posedge clk) begin
		if (!data_valid && idx == '0)
			snap <= frame;
	end

	always_comb begin
		data_byte.pixel = snap[{idx, 3'b000} +: 8];
	end

	// lcd_ctrl may latch the byte any time before en_tran
	a_hold_offer: assert property (@(posedge clk) disable iff (!rst_n)
		data_valid && !en_tran |=> data_valid && $stable(data_byte));

endmodule

`default_nettype wire

/* hw/lcd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "brainwars_config.svh"

module lcd_ctrl (
	input  logic clk, // system clock
	input  logic rst_n, // sync reset, active low
	input  logic data_valid, // streamer has a byte
	input  lcd_pkg::lcd_word_u data_byte, // byte from the streamer
	output logic LCD_rst, // panel reset, low = in reset
	output logic LCD_rw, // always write
	output logic LCD_di, // 0 instruction, 1 data
	output logic LCD_en, // write strobe
	output logic en_tran, // byte consumed this cycle
	output logic [1:0] LCD_cs, // half select
	output logic [7:0] LCD_data // bus word
);
	import lcd_pkg::*;

	// load states run in order, each one hands over to the next
	localparam logic [2:0] S_HOLD = 3'd0;
	localparam logic [2:0] S_INIT_ON = 3'd1;
	localparam logic [2:0] S_INIT_LINE = 3'd2;
	localparam logic [2:0] S_PAGE = 3'd3;
	localparam logic [2:0] S_COL = 3'd4;
	localparam logic [2:0] S_DATA = 3'd5;
	localparam logic [2:0] S_STROBE = 3'd6;

	localparam int RST_HOLD = 8; // cycles of LCD_rst low
	localparam int HW = $clog2(RST_HOLD);
	localparam int STB_LEN = 2 * `LCD_EN_CYCLES; // high then low time
	localparam int SW = $clog2(STB_LEN);
	localparam int BW = $clog2(`FRAME_BYTES);

	logic [2:0] state;
	logic [2:0] ret_state; // where the strobe returns to
	logic [HW-1:0] hold_cnt;
	logic [SW-1:0] stb_cnt;
	logic [BW-1:0] byte_cnt; // data writes in this frame

	function automatic lcd_word_u make_instr(input logic [1:0] op, input logic [5:0] arg);
		lcd_word_u w;
		w.instr.op = op;
		w.instr.arg = arg;
		return w;
	endfunction

	assign LCD_rw = 1'b0;
	assign LCD_cs = 2'b01; // left half
	assign en_tran = (state == S_DATA) && data_valid;

	////////////////////////////////////////////////////////////
	// sequencer
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_HOLD;
			ret_state <= S_HOLD;
			hold_cnt <= '0;
			stb_cnt <= '0;
			byte_cnt <= '0;
			LCD_rst <= 1'b0;
			LCD_en <= 1'b0;
			LCD_di <= 1'b0;
		end else begin
			case (state)
				S_HOLD: begin
					hold_cnt <= hold_cnt + 1'b1;
					if (hold_cnt == HW'(RST_HOLD - 1)) begin
						LCD_rst <= 1'b1; // release panel
						state <= S_INIT_ON;
					end
				end
				S_INIT_ON, S_INIT_LINE, S_PAGE, S_COL: begin
					LCD_di <= 1'b0; // instruction write
					ret_state <= state + 3'd1; // next in the chain
					byte_cnt <= '0;
					stb_cnt <= '0;
					state <= S_STROBE;
				end
				S_DATA: begin
					if (data_valid) begin
						LCD_di <= 1'b1;
						byte_cnt <= byte_cnt + 1'b1;
						ret_state <= (byte_cnt == BW'(`FRAME_BYTES - 1)) ? S_PAGE : S_DATA;
						stb_cnt <= '0;
						state <= S_STROBE;
					end
				end
				S_STROBE: begin
					LCD_en <= (stb_cnt < SW'(`LCD_EN_CYCLES)); // high first half
					stb_cnt <= stb_cnt + 1'b1;
					if (stb_cnt == SW'(STB_LEN - 1))
						state <= ret_state;
				end
				default: state <= S_HOLD;
			endcase
		end
	end

	// bus word, set one cycle before the strobe rises
	always_ff @(posedge clk) begin
		case (state)
			S_INIT_ON: LCD_data <= make_instr(OP_DISPLAY, ARG_DISPLAY_ON);
			S_INIT_LINE: LCD_data <= make_instr(OP_START, ARG_ZERO);
			S_PAGE: LCD_data <= make_instr(OP_PAGE, ARG_PAGE_BASE);
			S_COL: LCD_data <= make_instr(OP_COLUMN, ARG_ZERO);
			S_DATA: if (data_valid) LCD_data <= data_byte.pixel;
			default: ;
		endcase
	end

	// no write may reach a panel still in reset
	a_quiet_in_reset: assert property (@(posedge clk) disable iff (!rst_n)
		!LCD_rst |-> !LCD_en);

endmodule

`default_nettype wire

/* hw/brainwars_main.sv */
`timescale 1ns/1ps
`default_nettype none
`include "brainwars_config.svh"

module brainwars_main (
	input  logic clk, // system clock
	input  logic rst_n, // sync reset, active low
	input  logic game_en, // game enable
	input  logic [`KEYPAD_WIDTH-1:0] col_n, // keypad columns
	output logic [`KEYPAD_WIDTH-1:0] row_n, // keypad row strobe
	output logic LCD_rst, // LCD reset
	output logic [1:0] LCD_cs, // LCD half select
	output logic LCD_rw, // LCD read/write
	output logic LCD_di, // LCD data/instruction
	output logic [7:0] LCD_data, // LCD bus
	output logic LCD_en // LCD enable
);
	import game_pkg::*;
	import lcd_pkg::*;

	logic tick; // scan and debounce enable
	key_t key;
	logic pressed;
	logic press_pulse;
	logic [127:0] frame;
	lcd_word_u data_byte;
	logic data_valid;
	logic en_tran;

	////////////////////////////////////////////////////////////
	// keypad path
	////////////////////////////////////////////////////////////
	scan_tick scan_tick_i (
		.clk(clk), .rst_n(rst_n), .tick(tick)
	);

	keypad_scan keypad_scan_i (
		.clk(clk), .rst_n(rst_n), .tick(tick), .col_n(col_n),
		.row_n(row_n), .key(key), .pressed(pressed)
	);

	debounce_one_pulse debounce_one_pulse_i (
		.clk(clk), .rst_n(rst_n), .tick(tick), .pressed(pressed),
		.press_pulse(press_pulse)
	);

	flick_game flick_game_i (
		.clk(clk), .rst_n(rst_n), .game_en(game_en), .press_pulse(press_pulse),
		.key(key), .frame(frame)
	);

	////////////////////////////////////////////////////////////
	// LCD path
	////////////////////////////////////////////////////////////
	frame_ram_ctrl frame_ram_ctrl_i (
		.clk(clk), .rst_n(rst_n), .en_tran(en_tran), .frame(frame),
		.data_byte(data_byte), .data_valid(data_valid)
	);

	lcd_ctrl lcd_ctrl_i (
		.clk(clk), .rst_n(rst_n), .data_valid(data_valid), .data_byte(data_byte),
		.LCD_rst(LCD_rst), .LCD_rw(LCD_rw), .LCD_di(LCD_di), .LCD_en(LCD_en),
		.en_tran(en_tran), .LCD_cs(LCD_cs), .LCD_data(LCD_data)
	);

endmodule

`default_nettype wire

/* testbench/brainwars_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "brainwars_config.svh"

module brainwars_tb;
	import game_pkg::*;
	import lcd_pkg::*;

	localparam int KW = `KEYPAD_WIDTH;
	localparam int HOLD_TICKS = 2 * KW + `DEB_TICKS + 2; // reach the row, then debounce
	localparam int RELEASE_TICKS = 2 * KW + `DEB_TICKS + 2; // quiet sweep, then rearm
	localparam int LONG_TICKS = 10 * KW; // many full scans
	localparam int FRAMES_TOTAL = 2 + 2 + 9 + 3 + 8; // init, idle, hits, miss, hold
	localparam int WATCHDOG_NS = 2 * FRAMES_TOTAL * 40 * (2 * `LCD_EN_CYCLES + 4) * 40;

	logic clk;
	logic rst_n;
	logic game_en;
	logic [KW-1:0] col_n;
	logic [KW-1:0] row_n;
	logic LCD_rst;
	logic [1:0] LCD_cs;
	logic LCD_rw;
	logic LCD_di;
	logic [7:0] LCD_data;
	logic LCD_en;

	logic holding; // keypad model has a key down
	key_t held_key;
	logic [8:0] lcd_q [$]; // {di, data} per write
	logic [7:0] frame_data [16]; // data bytes of the last frame read
	logic frame_di [16];
	lfsr_t exp_lfsr; // reference target generator
	score_t exp_hit;
	score_t exp_miss;
	integer seed;
	int err_cnt;
	int tests_run;
	int tests_failed;

	brainwars_main brainwars_main_i (
		.clk(clk), .rst_n(rst_n), .game_en(game_en), .col_n(col_n), .row_n(row_n),
		.LCD_rst(LCD_rst), .LCD_cs(LCD_cs), .LCD_rw(LCD_rw), .LCD_di(LCD_di),
		.LCD_data(LCD_data), .LCD_en(LCD_en)
	);

	always #20 clk = ~clk; // 40 ns period

	////////////////////////////////////////////////////////////
	// keypad model and LCD bus monitor
	////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		if (holding && !row_n[held_key[3:2]]) // held key's row strobed
			col_n <= ~(KW'(1) << held_key[1:0]);
		else
			col_n <= '1;
	end

	always @(negedge LCD_en) begin
		if (rst_n === 1'b1) begin // skip x to 0 at power up
			lcd_q.push_back({LCD_di, LCD_data});
			if (LCD_rst !== 1'b1 || LCD_rw !== 1'b0 || LCD_cs !== 2'b01) begin
				$display("LCD write seen with panel in reset, bus in read or wrong half");
				err_cnt++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// reference model and compare tasks
	////////////////////////////////////////////////////////////
	task automatic advance_lfsr();
		logic fb;
		fb = exp_lfsr[15] ^ exp_lfsr[13] ^ exp_lfsr[12] ^ exp_lfsr[10]; // taps 16,14,13,11
		exp_lfsr = {exp_lfsr[14:0], fb}; // shift left
	endtask

	function automatic key_t target_of(input lfsr_t s);
		return key_t'(s[3:0] % 14); // low nibble folded onto 14 keys
	endfunction

	function automatic lcd_word_u word_of(input logic [7:0] b);
		lcd_word_u w;
		w.pixel = b;
		return w;
	endfunction

	task automatic count_hit();
		if (exp_hit != 8'hFF)
			exp_hit++; // saturates
		advance_lfsr();
	endtask

	task automatic count_miss();
		if (exp_miss != 8'hFF)
			exp_miss++;
	endtask

	task automatic check_byte(input string name, input lcd_word_u exp, input logic exp_di,
		input lcd_word_u act, input logic act_di);
		if (act.pixel !== exp.pixel || act_di !== exp_di) begin
			$display("error %s: expected %h di %b, actual %h di %b",
				name, exp.pixel, exp_di, act.pixel, act_di);
			err_cnt++;
		end
	endtask

	task automatic check_score(input string name, input score_t exp, input score_t act);
		if (act !== exp) begin
			$display("error %s: expected %0d, actual %0d", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic get_write(output lcd_word_u w, output logic di);
		logic [8:0] e;
		while (lcd_q.size() == 0) // watchdog bounds the wait
			@(posedge clk);
		e = lcd_q.pop_front();
		w.pixel = e[7:0];
		di = e[8];
	endtask

	// header then 16 data bytes; non-strict skips to the next page write
	task automatic read_frame(input string name, input logic strict);
		lcd_word_u w;
		logic di;
		get_write(w, di);
		if (!strict) begin
			while (di !== 1'b0 || w.pixel !== 8'hB8)
				get_write(w, di);
		end else begin
			check_byte(name, word_of(8'hB8), 1'b0, w, di); // page 0
		end
		get_write(w, di);
		check_byte(name, word_of(8'h40), 1'b0, w, di); // column 0
		for (int k = 0; k < `FRAME_BYTES; k++) begin
			get_write(w, di);
			frame_data[k] = w.pixel;
			frame_di[k] = di;
		end
	endtask

	task automatic check_frame(input string name);
		lcd_word_u w;
		lcd_word_u exp;
		key_t tgt;
		lcd_q.delete();
		read_frame(name, 1'b0); // snapshot may predate the press
		read_frame(name, 1'b1);
		tgt = target_of(exp_lfsr);
		for (int k = 0; k < 14; k++) begin
			w.pixel = frame_data[k];
			exp.pixel = (key_t'(k) == tgt) ? 8'hFF : 8'h00; // bar on target only
			check_byte(name, exp, 1'b1, w, frame_di[k]);
		end
		if (frame_di[14] !== 1'b1 || frame_di[15] !== 1'b1) begin
			$display("%s: score bytes were not written as data", name);
			err_cnt++;
		end
		check_score({name, " miss"}, exp_miss, score_t'(frame_data[14]));
		check_score({name, " hit"}, exp_hit, score_t'(frame_data[15]));
	endtask

	task automatic press_key(input key_t k, input int ticks);
		@(posedge clk);
		held_key <= k;
		holding <= 1'b1;
		repeat (ticks * `SCAN_DIV) @(posedge clk);
		holding <= 1'b0;
		repeat (RELEASE_TICKS * `SCAN_DIV) @(posedge clk); // scanner and debounce settle
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (err_cnt == errs_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, err_cnt - errs_before);
		end
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////
	task automatic test_init_sequence();
		int e0;
		lcd_word_u w;
		logic di;
		e0 = err_cnt;
		if (LCD_rst !== 1'b0 || LCD_en !== 1'b0) begin
			$display("init: LCD not held in reset right after reset release");
			err_cnt++;
		end
		get_write(w, di);
		check_byte("init", word_of(8'h3F), 1'b0, w, di); // display on
		get_write(w, di);
		check_byte("init", word_of(8'hC0), 1'b0, w, di); // start line 0
		read_frame("init", 1'b1);
		read_frame("init", 1'b1); // header comes back every frame
		report_test("init", e0);
	endtask

	task automatic test_idle_frame();
		int e0;
		e0 = err_cnt;
		check_frame("idle");
		report_test("idle", e0);
	endtask

	task automatic test_hits();
		int e0;
		e0 = err_cnt;
		repeat (3) begin
			press_key(target_of(exp_lfsr), HOLD_TICKS);
			count_hit(); // target moves on
			check_frame("hits");
		end
		report_test("hits", e0);
	endtask

	task automatic test_wrong_key();
		int e0;
		integer r;
		key_t k;
		e0 = err_cnt;
		r = $random(seed);
		k = r[3:0];
		while (k == target_of(exp_lfsr)) begin // redraw until it misses
			r = $random(seed);
			k = r[3:0];
		end
		press_key(k, HOLD_TICKS);
		count_miss();
		check_frame("miss");
		report_test("miss", e0);
	endtask

	task automatic test_hold_and_disable();
		int e0;
		key_t k;
		e0 = err_cnt;
		press_key(target_of(exp_lfsr), LONG_TICKS); // long hold, one hit
		count_hit();
		check_frame("hold");
		@(posedge clk);
		game_en <= 1'b0;
		press_key(target_of(exp_lfsr), HOLD_TICKS); // ignored
		k = target_of(exp_lfsr) + 4'd1;
		press_key(k, HOLD_TICKS); // ignored too
		check_frame("disabled");
		@(posedge clk);
		game_en <= 1'b1;
		report_test("hold", e0);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		game_en = 1'b0;
		col_n = '1;
		holding = 1'b0;
		held_key = '0;
		seed = 93;
		err_cnt = 0;
		tests_run = 0;
		tests_failed = 0;
		exp_lfsr = `LFSR_SEED;
		exp_hit = '0;
		exp_miss = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		game_en <= 1'b1;
		lcd_q.delete();
		test_init_sequence();
		test_idle_frame();
		test_hits();
		test_wrong_key();
		test_hold_and_disable();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the LCD stream stopped before all tests finished");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/game_pkg.sv
hw/lcd_pkg.sv
hw/scan_tick.sv
hw/keypad_scan.sv
hw/debounce_one_pulse.sv
hw/flick_game.sv
hw/frame_ram_ctrl.sv
hw/lcd_ctrl.sv
hw/brainwars_main.sv
testbench/brainwars_tb.sv
